//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Architectural widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] pc_t;

  //////////////////////////////////////////////////////////////////////
  // ALU operation codes
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_AND   = 4'd2;
  localparam alu_op_t ALU_OR    = 4'd3;
  localparam alu_op_t ALU_XOR   = 4'd4;
  localparam alu_op_t ALU_SLL   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_SLT   = 4'd8;
  localparam alu_op_t ALU_SLTU  = 4'd9;
  localparam alu_op_t ALU_LUI   = 4'd10;
  localparam alu_op_t ALU_AUIPC = 4'd11;
  // jal/jalr return address
  localparam alu_op_t ALU_LINK  = 4'd12;

  // Branch compare codes
  typedef logic [2:0] cmp_op_t;
  localparam cmp_op_t CMP_EQ  = 3'd0;
  localparam cmp_op_t CMP_NE  = 3'd1;
  localparam cmp_op_t CMP_LT  = 3'd2;
  localparam cmp_op_t CMP_GE  = 3'd3;
  localparam cmp_op_t CMP_LTU = 3'd4;
  localparam cmp_op_t CMP_GEU = 3'd5;

  // Multiply selector
  typedef logic [1:0] mul_op_t;
  localparam mul_op_t MUL_NONE  = 2'd0;
  localparam mul_op_t MUL_LO    = 2'd1;
  localparam mul_op_t MUL_HI_UU = 2'd2;

endpackage

`default_nettype wire

//--- rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  //////////////////////////////////////////////////////////////////////
  // Operand forwarding source select
  typedef logic [1:0] fwd_sel_t;
  // Register file value from decode
  localparam fwd_sel_t FWD_REG   = 2'd0;
  // Result of the instruction one ahead
  localparam fwd_sel_t FWD_EXMEM = 2'd1;
  // Two ahead
  localparam fwd_sel_t FWD_MEMWB = 2'd2;
  // Write-back value not yet in the register file
  localparam fwd_sel_t FWD_WBID  = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Iterative multiplier FSM
  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_DONE
  } mul_state_t;

  // Multiplier bits retired per cycle
  localparam int MUL_BITS_DEFAULT = 2;

endpackage

`default_nettype wire

//--- id_ex_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction fields at the ID/EX boundary
interface id_ex_if;
  import rv_isa_pkg::*;

  // Register indices and operand values
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    imm;
  pc_t      pc;

  // Execute controls
  alu_op_t  alu_op;
  cmp_op_t  cmp_op;
  logic     compare;
  logic     alusrc;
  mul_op_t  mul_op;

  // Controls carried on to later stages
  logic     memread;
  logic     memwrite;
  logic     regwrite;

  // Whole instruction, read by the stage
  modport stage (
    input rs1, rs2, rd, rs1_data, rs2_data, imm, pc,
    input alu_op, cmp_op, compare, alusrc, mul_op,
    input memread, memwrite, regwrite
  );

  // Only what operand selection needs
  modport fwd (input rs1, rs2, rs1_data, rs2_data, imm, alusrc);

endinterface

`default_nettype wire

//--- operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
  id_ex_if.fwd                port,
  input  logic                exmem_regwrite,
  input  rv_isa_pkg::reg_idx_t exmem_rd,
  input  rv_isa_pkg::word_t    exmem_res,
  input  logic                memwb_regwrite,
  input  rv_isa_pkg::reg_idx_t memwb_rd,
  input  rv_isa_pkg::word_t    memwb_res,
  input  logic                wbid_regwrite,
  input  rv_isa_pkg::reg_idx_t wbid_rd,
  input  rv_isa_pkg::word_t    wbid_res,
  output rv_isa_pkg::word_t    op_a,
  output rv_isa_pkg::word_t    op_b,
  output rv_isa_pkg::word_t    store_data
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  fwd_sel_t sel_a;
  fwd_sel_t sel_b;

  // Youngest matching producer wins, x0 never forwarded
  function automatic fwd_sel_t pick_src(reg_idx_t idx);
    fwd_sel_t sel;
    sel = FWD_REG;
    if (idx != '0)
    begin
      if (exmem_regwrite && exmem_rd == idx)
        sel = FWD_EXMEM;
      else if (memwb_regwrite && memwb_rd == idx)
        sel = FWD_MEMWB;
      else if (wbid_regwrite && wbid_rd == idx)
        sel = FWD_WBID;
    end
    return sel;
  endfunction

  function automatic word_t fwd_val(fwd_sel_t sel, word_t reg_val);
    case (sel)
      FWD_EXMEM: return exmem_res;
      FWD_MEMWB: return memwb_res;
      FWD_WBID:  return wbid_res;
      default:   return reg_val;
    endcase
  endfunction

  always_comb
  begin
    sel_a      = pick_src(port.rs1);
    sel_b      = pick_src(port.rs2);
    op_a       = fwd_val(sel_a, port.rs1_data);
    // Stores always take the forwarded rs2, never the immediate
    store_data = fwd_val(sel_b, port.rs2_data);
  end

  // Second ALU operand
  assign op_b = port.alusrc ? port.imm : store_data;

endmodule

`default_nettype wire

//--- int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input  rv_isa_pkg::word_t   a,
  input  rv_isa_pkg::word_t   b,
  input  rv_isa_pkg::pc_t     pc,
  input  rv_isa_pkg::alu_op_t alu_op,
  input  rv_isa_pkg::cmp_op_t cmp_op,
  output rv_isa_pkg::word_t   res,
  output logic                cmp_true
);
  import rv_isa_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  // Shared relations for slt and branches
  assign shamt = b[4:0];
  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);

  //////////////////////////////////////////////////////////////////////
  // Result select
  always_comb
  begin
    case (alu_op)
      ALU_ADD:   res = a + b;
      ALU_SUB:   res = a - b;
      ALU_AND:   res = a & b;
      ALU_OR:    res = a | b;
      ALU_XOR:   res = a ^ b;
      ALU_SLL:   res = a << shamt;
      ALU_SRL:   res = a >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:   res = word_t'($signed(a) >>> shamt);
      ALU_SLT:   res = {31'b0, lt_s};
      ALU_SLTU:  res = {31'b0, lt_u};
      // Immediate arrives already shifted up by decode
      ALU_LUI:   res = b;
      ALU_AUIPC: res = pc + b;
      // Return address for jal/jalr
      ALU_LINK:  res = pc + 32'd4;
      default:   res = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Branch relation
  always_comb
  begin
    case (cmp_op)
      CMP_EQ:  cmp_true = eq;
      CMP_NE:  cmp_true = !eq;
      CMP_LT:  cmp_true = lt_s;
      CMP_GE:  cmp_true = !lt_s;
      CMP_LTU: cmp_true = lt_u;
      CMP_GEU: cmp_true = !lt_u;
      // Unused codes never take the branch
      default: cmp_true = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- seq_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier #(
  parameter int MUL_BITS_PER_CYCLE = rv_pipe_pkg::MUL_BITS_DEFAULT
) (
  input  logic                bus,
  input  logic                rst_n,
  input  logic                start,
  input  rv_isa_pkg::mul_op_t mul_op,
  input  rv_isa_pkg::word_t   a,
  input  rv_isa_pkg::word_t   b,
  output logic                busy,
  output rv_isa_pkg::word_t   res
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int STEPS = 32 / MUL_BITS_PER_CYCLE;
  localparam int CNT_W = $clog2(STEPS);

  mul_state_t       state;
  logic [CNT_W-1:0] cnt;
  logic             load;
  logic [63:0]      acc;
  logic [63:0]      mcand;
  logic [31:0]      mplier;
  logic [63:0]      step_sum;
  mul_op_t          op_q;

  assign busy = (state == MUL_RUN);
  assign load = start && !busy;

  // Shift-add over the low multiplier bits of this step
  always_comb
  begin
    step_sum = acc;
    for (int i = 0; i < MUL_BITS_PER_CYCLE; i++)
    begin
      if (mplier[i])
        step_sum = step_sum + (mcand << i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM and step counter
  always_ff @(posedge bus or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= MUL_IDLE;
      cnt   <= '0;
    end
    else if (load)
    begin
      state <= MUL_RUN;
      cnt   <= CNT_W'(STEPS - 1);
    end
    else if (state == MUL_RUN)
    begin
      // Last step moves to DONE with the product complete
      if (cnt == '0)
        state <= MUL_DONE;
      else
        cnt <= cnt - 1'b1;
    end
    else
      state <= MUL_IDLE;
  end

  // Operand shifters and partial product
  always_ff @(posedge bus)
  begin
    if (load)
    begin
      acc    <= '0;
      mcand  <= {32'b0, a};
      mplier <= b;
      op_q   <= mul_op;
    end
    else if (busy)
    begin
      acc    <= step_sum;
      mcand  <= mcand << MUL_BITS_PER_CYCLE;
      mplier <= mplier >> MUL_BITS_PER_CYCLE;
    end
  end

  // Product held until the next start
  assign res = (op_q == MUL_HI_UU) ? acc[63:32] : acc[31:0];

  // Stage must not restart a multiply in flight
  a_no_start_busy: assert property (@(posedge bus) disable iff (!rst_n) busy |-> !start);

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
  parameter int MUL_BITS_PER_CYCLE = rv_pipe_pkg::MUL_BITS_DEFAULT
) (
  input  logic                 bus,
  input  logic                 rst_n,
  input  logic                 mem_hold,
  id_ex_if.stage               id,
  id_ex_if.fwd                 ff,
  input  logic                 memwb_regwrite,
  input  rv_isa_pkg::reg_idx_t memwb_rd,
  input  rv_isa_pkg::word_t    memwb_res,
  input  logic                 wbid_regwrite,
  input  rv_isa_pkg::reg_idx_t wbid_rd,
  input  rv_isa_pkg::word_t    wbid_res,
  output rv_isa_pkg::word_t    ex_mem_res,
  output rv_isa_pkg::reg_idx_t ex_mem_rd,
  output logic                 ex_mem_regwrite,
  output logic                 ex_mem_memread,
  output logic                 ex_mem_memwrite,
  output rv_isa_pkg::word_t    ex_mem_store_data,
  output logic                 ex_mem_comp_res,
  output rv_isa_pkg::pc_t      ex_mem_pc,
  output logic                 mul_busy
);
  import rv_isa_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t store_data;
  word_t alu_res;
  word_t mul_res;
  logic  cmp_true;
  logic  is_mul;
  logic  mul_start;
  logic  busy_q;
  logic  mul_done;
  logic  mul_ready;
  logic  stage_en;

  operand_forward u_fwd (
    .port(ff),
    .exmem_regwrite(ex_mem_regwrite),
    .exmem_rd(ex_mem_rd),
    .exmem_res(ex_mem_res),
    .memwb_regwrite(memwb_regwrite),
    .memwb_rd(memwb_rd),
    .memwb_res(memwb_res),
    .wbid_regwrite(wbid_regwrite),
    .wbid_rd(wbid_rd),
    .wbid_res(wbid_res),
    .op_a(op_a),
    .op_b(op_b),
    .store_data(store_data)
  );

  int_alu u_alu (
    .a(op_a),
    .b(op_b),
    .pc(id.pc),
    .alu_op(id.alu_op),
    .cmp_op(id.cmp_op),
    .res(alu_res),
    .cmp_true(cmp_true)
  );

  // Multiply uses forwarded rs2, never the immediate
  seq_multiplier #(
    .MUL_BITS_PER_CYCLE(MUL_BITS_PER_CYCLE)
  ) u_mul (
    .bus(bus),
    .rst_n(rst_n),
    .start(mul_start),
    .mul_op(id.mul_op),
    .a(op_a),
    .b(store_data),
    .busy(mul_busy),
    .res(mul_res)
  );

  //////////////////////////////////////////////////////////////////////
  // Multiply handshake and stall
  assign is_mul    = (id.mul_op != MUL_NONE);
  // Falling busy means the product is in place
  assign mul_done  = busy_q && !mul_busy;
  assign mul_start = is_mul && !mul_busy && !mul_done && !mul_ready;
  assign stage_en  = !mem_hold && !mul_busy && (!is_mul || mul_done || mul_ready);

  always_ff @(posedge bus or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q    <= 1'b0;
      mul_ready <= 1'b0;
    end
    else
    begin
      busy_q <= mul_busy;
      // Product kept across a memory hold
      if (stage_en)
        mul_ready <= 1'b0;
      else if (mul_done)
        mul_ready <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/MEM register, control half
  always_ff @(posedge bus or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_mem_rd       <= '0;
      ex_mem_regwrite <= 1'b0;
      ex_mem_memread  <= 1'b0;
      ex_mem_memwrite <= 1'b0;
      ex_mem_comp_res <= 1'b0;
    end
    else if (stage_en)
    begin
      ex_mem_rd       <= id.rd;
      // Compare ops write back only when the relation holds
      ex_mem_regwrite <= id.regwrite && (!id.compare || cmp_true);
      ex_mem_memread  <= id.memread;
      ex_mem_memwrite <= id.memwrite;
      ex_mem_comp_res <= cmp_true;
    end
  end

  // Data half
  always_ff @(posedge bus)
  begin
    if (stage_en)
    begin
      ex_mem_res        <= is_mul ? mul_res : alu_res;
      ex_mem_store_data <= store_data;
      ex_mem_pc         <= id.pc;
    end
  end

  // Decode never marks an instruction as both load and store
  a_rd_wr_excl: assert property (@(posedge bus) disable iff (!rst_n)
    !(ex_mem_memread && ex_mem_memwrite));

endmodule

`default_nettype wire

//--- exec_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_subsystem_top #(
  parameter int MUL_BITS_PER_CYCLE = rv_pipe_pkg::MUL_BITS_DEFAULT
) (
  input  logic                 bus,
  input  logic                 rst_n,
  input  logic                 mem_hold,
  // ID/EX instruction
  input  rv_isa_pkg::reg_idx_t id_rs1,
  input  rv_isa_pkg::reg_idx_t id_rs2,
  input  rv_isa_pkg::reg_idx_t id_rd,
  input  rv_isa_pkg::word_t    id_rs1_data,
  input  rv_isa_pkg::word_t    id_rs2_data,
  input  rv_isa_pkg::word_t    id_imm,
  input  rv_isa_pkg::pc_t      id_pc,
  input  rv_isa_pkg::alu_op_t  id_alu_op,
  input  rv_isa_pkg::cmp_op_t  id_cmp_op,
  input  logic                 id_compare,
  input  logic                 id_alusrc,
  input  rv_isa_pkg::mul_op_t  id_mul_op,
  input  logic                 id_memread,
  input  logic                 id_memwrite,
  input  logic                 id_regwrite,
  // Later-stage forwarding sources
  input  logic                 memwb_regwrite,
  input  rv_isa_pkg::reg_idx_t memwb_rd,
  input  rv_isa_pkg::word_t    memwb_res,
  input  logic                 wbid_regwrite,
  input  rv_isa_pkg::reg_idx_t wbid_rd,
  input  rv_isa_pkg::word_t    wbid_res,
  // EX/MEM boundary
  output rv_isa_pkg::word_t    ex_mem_res,
  output rv_isa_pkg::reg_idx_t ex_mem_rd,
  output logic                 ex_mem_regwrite,
  output logic                 ex_mem_memread,
  output logic                 ex_mem_memwrite,
  output rv_isa_pkg::word_t    ex_mem_store_data,
  output logic                 ex_mem_comp_res,
  output rv_isa_pkg::pc_t      ex_mem_pc,
  output logic                 mul_busy
);

  id_ex_if id_ex ();

  // Pack the decoded fields into the bundle
  assign id_ex.rs1      = id_rs1;
  assign id_ex.rs2      = id_rs2;
  assign id_ex.rd       = id_rd;
  assign id_ex.rs1_data = id_rs1_data;
  assign id_ex.rs2_data = id_rs2_data;
  assign id_ex.imm      = id_imm;
  assign id_ex.pc       = id_pc;
  assign id_ex.alu_op   = id_alu_op;
  assign id_ex.cmp_op   = id_cmp_op;
  assign id_ex.compare  = id_compare;
  assign id_ex.alusrc   = id_alusrc;
  assign id_ex.mul_op   = id_mul_op;
  assign id_ex.memread  = id_memread;
  assign id_ex.memwrite = id_memwrite;
  assign id_ex.regwrite = id_regwrite;

  execute_stage #(
    .MUL_BITS_PER_CYCLE(MUL_BITS_PER_CYCLE)
  ) u_exec (
    .bus(bus),
    .rst_n(rst_n),
    .mem_hold(mem_hold),
    .id(id_ex),
    .ff(id_ex),
    .memwb_regwrite(memwb_regwrite),
    .memwb_rd(memwb_rd),
    .memwb_res(memwb_res),
    .wbid_regwrite(wbid_regwrite),
    .wbid_rd(wbid_rd),
    .wbid_res(wbid_res),
    .ex_mem_res(ex_mem_res),
    .ex_mem_rd(ex_mem_rd),
    .ex_mem_regwrite(ex_mem_regwrite),
    .ex_mem_memread(ex_mem_memread),
    .ex_mem_memwrite(ex_mem_memwrite),
    .ex_mem_store_data(ex_mem_store_data),
    .ex_mem_comp_res(ex_mem_comp_res),
    .ex_mem_pc(ex_mem_pc),
    .mul_busy(mul_busy)
  );

endmodule

`default_nettype wire

//--- tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top;
  import rv_isa_pkg::*;

  localparam int MUL_BITS = 2;
  // Generous margin over the few hundred cycles the tests take
  localparam int TIMEOUT_CYCLES = 2000;

  // One decoded instruction as presented at ID/EX
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    pc_t      pc;
    alu_op_t  alu_op;
    cmp_op_t  cmp_op;
    logic     compare;
    logic     alusrc;
    mul_op_t  mul_op;
    logic     memread;
    logic     memwrite;
    logic     regwrite;
  } instr_t;

  logic     bus;
  logic     rst_n;
  logic     mem_hold;
  instr_t   cur;
  logic     memwb_regwrite;
  reg_idx_t memwb_rd;
  word_t    memwb_res;
  logic     wbid_regwrite;
  reg_idx_t wbid_rd;
  word_t    wbid_res;

  word_t    ex_mem_res;
  reg_idx_t ex_mem_rd;
  logic     ex_mem_regwrite;
  logic     ex_mem_memread;
  logic     ex_mem_memwrite;
  word_t    ex_mem_store_data;
  logic     ex_mem_comp_res;
  pc_t      ex_mem_pc;
  logic     mul_busy;

  integer   seed;
  int       cycles;

  // Model copy of the EX/MEM register as seen by forwarding
  logic     prev_we;
  reg_idx_t prev_rd;
  word_t    prev_res;

  // Expected EX/MEM contents for the instruction in flight
  word_t    exp_res;
  reg_idx_t exp_rd;
  logic     exp_we;
  logic     exp_mrd;
  logic     exp_mwr;
  word_t    exp_store;
  logic     exp_cmp;
  pc_t      exp_pc;

  exec_subsystem_top #(
    .MUL_BITS_PER_CYCLE(MUL_BITS)
  ) dut0 (
    .bus(bus),
    .rst_n(rst_n),
    .mem_hold(mem_hold),
    .id_rs1(cur.rs1),
    .id_rs2(cur.rs2),
    .id_rd(cur.rd),
    .id_rs1_data(cur.rs1_data),
    .id_rs2_data(cur.rs2_data),
    .id_imm(cur.imm),
    .id_pc(cur.pc),
    .id_alu_op(cur.alu_op),
    .id_cmp_op(cur.cmp_op),
    .id_compare(cur.compare),
    .id_alusrc(cur.alusrc),
    .id_mul_op(cur.mul_op),
    .id_memread(cur.memread),
    .id_memwrite(cur.memwrite),
    .id_regwrite(cur.regwrite),
    .memwb_regwrite(memwb_regwrite),
    .memwb_rd(memwb_rd),
    .memwb_res(memwb_res),
    .wbid_regwrite(wbid_regwrite),
    .wbid_rd(wbid_rd),
    .wbid_res(wbid_res),
    .ex_mem_res(ex_mem_res),
    .ex_mem_rd(ex_mem_rd),
    .ex_mem_regwrite(ex_mem_regwrite),
    .ex_mem_memread(ex_mem_memread),
    .ex_mem_memwrite(ex_mem_memwrite),
    .ex_mem_store_data(ex_mem_store_data),
    .ex_mem_comp_res(ex_mem_comp_res),
    .ex_mem_pc(ex_mem_pc),
    .mul_busy(mul_busy)
  );

  // 20 ns clock
  initial
  begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp)
    begin
      $display("[FAIL] %s: got %h, expected %h", name, act, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t act, input reg_idx_t exp);
    if (act !== exp)
    begin
      $display("[FAIL] %s: got %h, expected %h", name, act, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("[FAIL] %s: got %h, expected %h", name, act, exp);
      stop_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  // Youngest producer first, x0 stays on the register path
  function automatic word_t fwd_pick(input reg_idx_t idx, input word_t reg_val);
    if (idx == '0)
      return reg_val;
    if (prev_we && prev_rd == idx)
      return prev_res;
    if (memwb_regwrite && memwb_rd == idx)
      return memwb_res;
    if (wbid_regwrite && wbid_rd == idx)
      return wbid_res;
    return reg_val;
  endfunction

  function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b,
                                      input pc_t pc);
    case (op)
      ALU_ADD:   return a + b;
      ALU_SUB:   return a - b;
      ALU_AND:   return a & b;
      ALU_OR:    return a | b;
      ALU_XOR:   return a ^ b;
      ALU_SLL:   return a << b[4:0];
      ALU_SRL:   return a >> b[4:0];
      ALU_SRA:   return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      ALU_LUI:   return b;
      ALU_AUIPC: return pc + b;
      ALU_LINK:  return pc + 32'd4;
      default:   return '0;
    endcase
  endfunction

  function automatic logic cmp_model(input cmp_op_t op, input word_t a, input word_t b);
    case (op)
      CMP_EQ:  return a == b;
      CMP_NE:  return a != b;
      CMP_LT:  return $signed(a) < $signed(b);
      CMP_GE:  return $signed(a) >= $signed(b);
      CMP_LTU: return a < b;
      CMP_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Expected EX/MEM values once this instruction is registered
  task automatic set_expect(input instr_t i);
    word_t       a;
    word_t       rs2v;
    word_t       b;
    logic [63:0] prod;
    logic        rel;
    a    = fwd_pick(i.rs1, i.rs1_data);
    rs2v = fwd_pick(i.rs2, i.rs2_data);
    b    = i.alusrc ? i.imm : rs2v;
    rel  = cmp_model(i.cmp_op, a, b);
    // Multiply always takes rs2, never the immediate
    prod = {32'b0, a} * {32'b0, rs2v};
    case (i.mul_op)
      MUL_LO:    exp_res = prod[31:0];
      MUL_HI_UU: exp_res = prod[63:32];
      default:   exp_res = alu_model(i.alu_op, a, b, i.pc);
    endcase
    exp_rd    = i.rd;
    exp_we    = i.regwrite && (!i.compare || rel);
    exp_mrd   = i.memread;
    exp_mwr   = i.memwrite;
    exp_store = rs2v;
    exp_cmp   = rel;
    exp_pc    = i.pc;
  endtask

  // Back-to-back dependency, last expectation sits in EX/MEM
  task automatic mark_prev();
    prev_we  = exp_we;
    prev_rd  = exp_rd;
    prev_res = exp_res;
  endtask

  task automatic clear_prev();
    prev_we = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic instr_t rand_alu_instr();
    instr_t i;
    int     k;
    i          = '0;
    i.rs1      = reg_idx_t'($random(seed));
    i.rs2      = reg_idx_t'($random(seed));
    i.rd       = reg_idx_t'($random(seed));
    i.rs1_data = word_t'($random(seed));
    i.rs2_data = word_t'($random(seed));
    i.imm      = word_t'($random(seed));
    i.pc       = pc_t'($random(seed)) & 32'hffff_fffc;
    i.alu_op   = alu_op_t'(rand_below(13));
    i.alusrc   = rand_below(2) == 1;
    i.regwrite = rand_below(2) == 1;
    // Load, store or neither, never both
    k          = rand_below(3);
    i.memread  = (k == 1);
    i.memwrite = (k == 2);
    return i;
  endfunction

  // Present an instruction on the rising edge
  task automatic issue(input instr_t i);
    @(posedge bus);
    cur <= i;
    set_expect(i);
  endtask

  // Capture edge, then a bubble behind it, sampled mid-cycle
  task automatic settle();
    @(posedge bus);
    cur <= '0;
    @(negedge bus);
  endtask

  task automatic check_outputs();
    check_word("ex_mem_res", ex_mem_res, exp_res);
    check_idx("ex_mem_rd", ex_mem_rd, exp_rd);
    check_bit("ex_mem_regwrite", ex_mem_regwrite, exp_we);
    check_bit("ex_mem_memread", ex_mem_memread, exp_mrd);
    check_bit("ex_mem_memwrite", ex_mem_memwrite, exp_mwr);
    check_word("ex_mem_store_data", ex_mem_store_data, exp_store);
    check_bit("ex_mem_comp_res", ex_mem_comp_res, exp_cmp);
    check_word("ex_mem_pc", ex_mem_pc, exp_pc);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (4) @(posedge bus);
    @(negedge bus);
    check_bit("ex_mem_regwrite", ex_mem_regwrite, 1'b0);
    check_bit("ex_mem_memread", ex_mem_memread, 1'b0);
    check_bit("ex_mem_memwrite", ex_mem_memwrite, 1'b0);
    check_bit("mul_busy", mul_busy, 1'b0);
    check_idx("ex_mem_rd", ex_mem_rd, 5'd0);
    @(posedge bus);
    rst_n <= 1'b1;
  endtask

  task automatic test_random_alu();
    instr_t i;
    repeat (40)
    begin
      i = rand_alu_instr();
      issue(i);
      settle();
      check_outputs();
    end
  endtask

  task automatic test_forwarding();
    instr_t a_ins;
    instr_t b_ins;
    instr_t c_ins;
    // MEM/WB also claims x7, WB/ID claims x0
    @(posedge bus);
    memwb_regwrite <= 1'b1;
    memwb_rd       <= 5'd7;
    memwb_res      <= word_t'($random(seed));
    wbid_regwrite  <= 1'b1;
    wbid_rd        <= 5'd0;
    wbid_res       <= word_t'($random(seed));
    a_ins          = rand_alu_instr();
    a_ins.rs1      = 5'd3;
    a_ins.rs2      = 5'd4;
    a_ins.rd       = 5'd7;
    a_ins.alu_op   = ALU_ADD;
    a_ins.alusrc   = 1'b0;
    a_ins.regwrite = 1'b1;
    issue(a_ins);
    mark_prev();
    // Dependent right behind, x7 from EX/MEM ahead of MEM/WB
    // x0 ignores the WB/ID claim
    b_ins          = rand_alu_instr();
    b_ins.rs1      = 5'd7;
    b_ins.rs2      = 5'd0;
    b_ins.rd       = 5'd9;
    b_ins.alu_op   = ALU_ADD;
    b_ins.alusrc   = 1'b0;
    issue(b_ins);
    clear_prev();
    settle();
    check_outputs();
    // Both later sources claim x8, MEM/WB must win
    @(posedge bus);
    memwb_rd       <= 5'd8;
    wbid_rd        <= 5'd8;
    c_ins          = rand_alu_instr();
    c_ins.rs1      = 5'd3;
    c_ins.rs2      = 5'd8;
    c_ins.alu_op   = ALU_ADD;
    c_ins.alusrc   = 1'b0;
    issue(c_ins);
    settle();
    check_outputs();
    @(posedge bus);
    memwb_regwrite <= 1'b0;
    wbid_regwrite  <= 1'b0;
  endtask

  task automatic test_compare();
    instr_t i;
    for (int n = 0; n < 20; n++)
    begin
      i          = rand_alu_instr();
      i.compare  = 1'b1;
      i.regwrite = 1'b1;
      i.alusrc   = 1'b0;
      i.cmp_op   = cmp_op_t'(rand_below(6));
      // Equal operands now and then for the EQ and GE paths
      if (n % 3 == 0)
        i.rs2_data = i.rs1_data;
      issue(i);
      settle();
      check_outputs();
    end
  endtask

  task automatic test_link_upper();
    instr_t i;
    i        = rand_alu_instr();
    i.alu_op = ALU_LINK;
    issue(i);
    settle();
    check_outputs();
    i        = rand_alu_instr();
    i.alu_op = ALU_AUIPC;
    i.alusrc = 1'b1;
    issue(i);
    settle();
    check_outputs();
    // Upper immediate with low 12 bits clear
    i        = rand_alu_instr();
    i.alu_op = ALU_LUI;
    i.alusrc = 1'b1;
    i.imm    = i.imm & 32'hffff_f000;
    issue(i);
    settle();
    check_outputs();
  endtask

  task automatic test_multiply();
    instr_t i;
    for (int n = 0; n < 6; n++)
    begin
      i          = rand_alu_instr();
      i.mul_op   = (n % 2 == 1) ? MUL_HI_UU : MUL_LO;
      i.alusrc   = 1'b0;
      i.regwrite = 1'b1;
      i.memread  = 1'b0;
      i.memwrite = 1'b0;
      issue(i);
      // Busy rises, then its fall ends the multiply
      @(negedge bus);
      while (!mul_busy)
        @(negedge bus);
      while (mul_busy)
        @(negedge bus);
      settle();
      check_outputs();
    end
  endtask

  task automatic test_mem_hold();
    instr_t x_ins;
    instr_t y_ins;
    x_ins          = rand_alu_instr();
    x_ins.regwrite = 1'b1;
    issue(x_ins);
    // Hold starts right as X is registered
    @(posedge bus);
    mem_hold <= 1'b1;
    y_ins    = rand_alu_instr();
    cur      <= y_ins;
    @(negedge bus);
    check_outputs();
    repeat (4)
    begin
      @(posedge bus);
      y_ins = rand_alu_instr();
      cur   <= y_ins;
      @(negedge bus);
      check_outputs();
    end
    // Last held instruction sees X in EX/MEM
    mark_prev();
    set_expect(y_ins);
    clear_prev();
    @(posedge bus);
    mem_hold <= 1'b0;
    settle();
    check_outputs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Cycle limit
  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge bus);
      cycles = cycles + 1;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycles);
    stop_with_failure();
  end

  // Main sequence
  initial
  begin
    seed           = 32002;
    prev_we        = 1'b0;
    prev_rd        = '0;
    prev_res       = '0;
    rst_n          <= 1'b0;
    mem_hold       <= 1'b0;
    cur            <= '0;
    memwb_regwrite <= 1'b0;
    memwb_rd       <= '0;
    memwb_res      <= '0;
    wbid_regwrite  <= 1'b0;
    wbid_rd        <= '0;
    wbid_res       <= '0;
    apply_reset();
    test_random_alu();
    test_forwarding();
    test_compare();
    test_link_upper();
    test_multiply();
    test_mem_hold();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
rv_isa_pkg.sv
rv_pipe_pkg.sv
id_ex_if.sv
operand_forward.sv
int_alu.sv
seq_multiplier.sv
execute_stage.sv
exec_subsystem_top.sv
tb_exec_top.sv

//--- run.sh
#!/bin/sh
# Compile the execute stage and its testbench, then run it.
# The simulator exits non-zero on any $fatal, which fails this script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_exec_top \
  -f project.f

./obj_dir/Vtb_exec_top
